//--- verilog/rv_pkg.sv
`default_nettype none

package rv_pkg;

  localparam int REG_ADDR_W = 4;
  localparam int INST_W     = 32;

  // funct12 codes under the privileged funct3
  localparam logic [11:0] FUNCT12_ECALL = 12'h000;
  localparam logic [11:0] FUNCT12_MRET  = 12'h302;

  typedef enum logic [6:0] {
    OP_LUI     = 7'b0110111,
    OP_AUIPC   = 7'b0010111,
    OP_JAL     = 7'b1101111,
    OP_JALR    = 7'b1100111,
    OP_BRANCH  = 7'b1100011,
    OP_LOAD    = 7'b0000011,
    OP_STORE   = 7'b0100011,
    OP_IMM     = 7'b0010011,
    OP_REG     = 7'b0110011,
    OP_SYSTEM  = 7'b1110011,
    OP_FENCE_I = 7'b0001111
  } opcode_e;

  // {funct7[5], funct3}
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SUB  = 4'b1000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_SRA  = 4'b1101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111
  } alu_op_e;

  typedef enum logic [2:0] {
    SYS_PRIV = 3'b000,
    CSRRW    = 3'b001,
    CSRRS    = 3'b010,
    CSRRC    = 3'b011,
    CSRRWI   = 3'b101,
    CSRRSI   = 3'b110,
    CSRRCI   = 3'b111
  } sys_funct_e;

  typedef enum logic [1:0] {
    OP1_ZERO = 2'd0,
    OP1_PC   = 2'd1,
    OP1_RS1  = 2'd2
  } op1_sel_e;

  typedef enum logic [1:0] {
    OP2_IMM  = 2'd0,
    OP2_FOUR = 2'd1,
    OP2_RS2  = 2'd2
  } op2_sel_e;

endpackage

`default_nettype wire

//--- verilog/decode_if.sv
`timescale 1ns/1ps
`default_nettype none

interface decode_if import rv_pkg::*; ();
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [REG_ADDR_W-1:0] rd;
  logic                  uses_rs1;
  logic                  uses_rs2;
  logic                  writes_rd;
  logic [31:0]           imm;
  alu_op_e               alu_op;
  op1_sel_e              op1_sel;
  op2_sel_e              op2_sel;
  logic                  is_jump;
  logic                  mem_read;
  logic                  mem_write;
  logic                  csr_write;
  logic                  system;
  logic                  illegal;

  modport dec (
    output rs1, rs2, rd, uses_rs1, uses_rs2, writes_rd, imm, alu_op, op1_sel, op2_sel,
    output is_jump, mem_read, mem_write, csr_write, system, illegal
  );

  modport iss (
    input rs1, rs2, rd, uses_rs1, uses_rs2, writes_rd, imm, alu_op, op1_sel, op2_sel,
    input is_jump, mem_read, mem_write, csr_write, system, illegal
  );
endinterface

`default_nettype wire

//--- verilog/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder import rv_pkg::*; (
  input  wire [INST_W-1:0] inst_i,
  decode_if.dec            dec
);
  opcode_e     opcode;
  sys_funct_e  sys_funct;
  logic [2:0]  funct3;
  logic        funct7_b5;
  logic        alt;
  alu_op_e     alu_funct;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;
  logic [31:0] imm_sys;

  assign opcode    = opcode_e'(inst_i[6:0]);
  assign funct3    = inst_i[14:12];
  assign funct7_b5 = inst_i[30];
  assign sys_funct = sys_funct_e'(funct3);

  // rv32e register fields, 4 bits
  assign dec.rs1 = inst_i[18:15];
  assign dec.rs2 = inst_i[23:20];

  assign imm_i   = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_s   = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  assign imm_b   = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  assign imm_u   = {inst_i[31:12], 12'b0};
  assign imm_j   = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
  // csr address sits above funct3
  assign imm_sys = {16'b0, inst_i[31:20], 1'b0, funct3};

  // funct7 bit 5 only for sub and sra/srai
  assign alt = ((opcode == OP_REG) && (funct3 == 3'b000 || funct3 == 3'b101) && funct7_b5) ||
               ((opcode == OP_IMM) && (funct3 == 3'b101) && funct7_b5);
  assign alu_funct = alu_op_e'({alt, funct3});

  always_comb begin
    dec.uses_rs1  = 1'b0;
    dec.uses_rs2  = 1'b0;
    dec.writes_rd = 1'b0;
    dec.imm       = '0;
    dec.alu_op    = ALU_ADD;
    dec.op1_sel   = OP1_ZERO;
    dec.op2_sel   = OP2_IMM;
    dec.is_jump   = 1'b0;
    dec.mem_read  = 1'b0;
    dec.mem_write = 1'b0;
    dec.csr_write = 1'b0;
    dec.system    = 1'b0;
    dec.illegal   = 1'b0;
    case (opcode)
      OP_LUI: begin
        dec.imm       = imm_u;
        dec.writes_rd = 1'b1;
      end
      OP_AUIPC: begin
        dec.imm       = imm_u;
        dec.op1_sel   = OP1_PC;
        dec.writes_rd = 1'b1;
      end
      // link value is pc + 4
      OP_JAL, OP_JALR: begin
        dec.imm       = (opcode == OP_JAL) ? imm_j : imm_i;
        dec.uses_rs1  = (opcode == OP_JALR);
        dec.op1_sel   = OP1_PC;
        dec.op2_sel   = OP2_FOUR;
        dec.writes_rd = 1'b1;
        dec.is_jump   = 1'b1;
      end
      OP_BRANCH: begin
        dec.imm      = imm_b;
        dec.alu_op   = alu_funct;
        dec.uses_rs1 = 1'b1;
        dec.uses_rs2 = 1'b1;
        dec.op1_sel  = OP1_RS1;
        dec.op2_sel  = OP2_RS2;
        dec.is_jump  = 1'b1;
      end
      OP_LOAD, OP_IMM: begin
        dec.imm       = imm_i;
        dec.alu_op    = alu_funct;
        dec.uses_rs1  = 1'b1;
        dec.op1_sel   = OP1_RS1;
        dec.writes_rd = 1'b1;
        dec.mem_read  = (opcode == OP_LOAD);
      end
      OP_STORE: begin
        dec.imm       = imm_s;
        dec.alu_op    = alu_funct;
        dec.uses_rs1  = 1'b1;
        dec.uses_rs2  = 1'b1;
        dec.op1_sel   = OP1_RS1;
        dec.op2_sel   = OP2_RS2;
        dec.mem_write = 1'b1;
      end
      OP_REG: begin
        dec.alu_op    = alu_funct;
        dec.uses_rs1  = 1'b1;
        dec.uses_rs2  = 1'b1;
        dec.op1_sel   = OP1_RS1;
        dec.op2_sel   = OP2_RS2;
        dec.writes_rd = 1'b1;
      end
      OP_SYSTEM: begin
        dec.imm     = imm_sys;
        dec.alu_op  = alu_funct;
        dec.op1_sel = OP1_RS1;
        dec.is_jump = 1'b1;
        dec.system  = 1'b1;
        case (sys_funct)
          SYS_PRIV: begin
            dec.csr_write = (inst_i[31:20] == FUNCT12_ECALL) ||
                            (inst_i[31:20] == FUNCT12_MRET);
          end
          CSRRW, CSRRS, CSRRC: begin
            dec.csr_write = 1'b1;
            dec.uses_rs1  = 1'b1;
            dec.writes_rd = 1'b1;
          end
          CSRRWI, CSRRSI, CSRRCI: begin
            dec.csr_write = 1'b1;
            dec.writes_rd = 1'b1;
          end
          default: dec.csr_write = 1'b0;
        endcase
      end
      OP_FENCE_I: dec.system = 1'b1;
      default: dec.illegal = 1'b1;
    endcase
    dec.rd = dec.writes_rd ? inst_i[10:7] : '0;
  end
endmodule

`default_nettype wire

//--- verilog/operand_unit.sv
`timescale 1ns/1ps
`default_nettype none

module operand_unit import rv_pkg::*; #(
  parameter int BIT_W = 32
) (
  input  wire                   clk,
  input  wire                   rst,
  input  wire  [REG_ADDR_W-1:0] rs1_i,
  input  wire  [REG_ADDR_W-1:0] rs2_i,
  input  wire                   issue_i,
  input  wire  [REG_ADDR_W-1:0] issue_rd_i,
  input  wire                   wb_valid_i,
  input  wire  [REG_ADDR_W-1:0] wb_rd_i,
  input  wire  [BIT_W-1:0]      wb_data_i,
  output logic [BIT_W-1:0]      rdata1_o,
  output logic [BIT_W-1:0]      rdata2_o,
  output logic                  busy1_o,
  output logic                  busy2_o
);
  localparam int NUM_REGS = 1 << REG_ADDR_W;

  logic [BIT_W-1:0]    regs [NUM_REGS];
  logic [NUM_REGS-1:0] busy;
  logic                byp1;
  logic                byp2;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_valid_i && wb_rd_i != '0) begin
      regs[wb_rd_i] <= wb_data_i;
    end
  end

  // set comes last, so a same-edge issue keeps rd busy
  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= '0;
    end else begin
      if (wb_valid_i) begin
        busy[wb_rd_i] <= 1'b0;
      end
      if (issue_i && issue_rd_i != '0) begin
        busy[issue_rd_i] <= 1'b1;
      end
    end
  end

  // writeback forwarding
  assign byp1 = wb_valid_i && (wb_rd_i == rs1_i);
  assign byp2 = wb_valid_i && (wb_rd_i == rs2_i);

  // x0 reads zero
  assign rdata1_o = (rs1_i == '0) ? '0 : (byp1 ? wb_data_i : regs[rs1_i]);
  assign rdata2_o = (rs2_i == '0) ? '0 : (byp2 ? wb_data_i : regs[rs2_i]);

  assign busy1_o = busy[rs1_i] && !byp1;
  assign busy2_o = busy[rs2_i] && !byp2;
endmodule

`default_nettype wire

//--- verilog/issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

module issue_stage import rv_pkg::*; #(
  parameter int BIT_W = 32
) (
  input  wire                   clk,
  input  wire                   rst,
  input  wire  [INST_W-1:0]     inst_i,
  input  wire  [BIT_W-1:0]      pc_i,
  input  wire                   prev_valid_i,
  output logic                  ready_o,
  input  wire                   next_ready_i,
  output logic                  valid_o,
  output logic [INST_W-1:0]     held_inst_o,
  decode_if.iss                 dec,
  input  wire  [BIT_W-1:0]      rdata1_i,
  input  wire  [BIT_W-1:0]      rdata2_i,
  input  wire                   busy1_i,
  input  wire                   busy2_i,
  output logic                  issue_o,
  output logic [REG_ADDR_W-1:0] issue_rd_o,
  output logic [BIT_W-1:0]      op1_o,
  output logic [BIT_W-1:0]      op2_o,
  output logic [BIT_W-1:0]      mem_addr_o,
  output logic [BIT_W-1:0]      jump_base_o,
  output logic [31:0]           imm_o,
  output alu_op_e               alu_op_o,
  output logic [REG_ADDR_W-1:0] rd_o,
  output logic                  is_jump_o,
  output logic                  mem_read_o,
  output logic                  mem_write_o,
  output logic                  csr_write_o,
  output logic                  system_o,
  output logic                  illegal_o,
  output logic [BIT_W-1:0]      pc_o
);
  logic [INST_W-1:0] inst_q;
  logic [BIT_W-1:0]  pc_q;
  logic              valid_q;
  logic              hazard;
  logic              accept;
  logic              fire;
  logic [BIT_W-1:0]  imm_ext;
  opcode_e           opcode;

  // stall only on sources the instruction actually reads
  assign hazard  = (dec.uses_rs1 && busy1_i) || (dec.uses_rs2 && busy2_i);
  assign valid_o = valid_q && !hazard;
  assign fire    = valid_o && next_ready_i;
  assign ready_o = !valid_q || fire;
  assign accept  = prev_valid_i && ready_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (fire) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      inst_q <= inst_i;
      pc_q   <= pc_i;
    end
  end

  assign held_inst_o = inst_q;
  assign pc_o        = pc_q;
  assign opcode      = opcode_e'(inst_q[6:0]);

  // scoreboard marks rd when a writer leaves
  assign issue_o    = fire && dec.writes_rd && (dec.rd != '0);
  assign issue_rd_o = dec.rd;

  assign imm_ext = BIT_W'($signed(dec.imm));

  always_comb begin
    case (dec.op1_sel)
      OP1_PC:  op1_o = pc_q;
      OP1_RS1: op1_o = rdata1_i;
      default: op1_o = '0;
    endcase
    case (dec.op2_sel)
      OP2_FOUR: op2_o = BIT_W'(4);
      OP2_RS2:  op2_o = rdata2_i;
      default:  op2_o = imm_ext;
    endcase
  end

  assign mem_addr_o = (dec.mem_read || dec.mem_write) ? rdata1_i + imm_ext : '0;

  always_comb begin
    case (opcode)
      OP_JAL, OP_BRANCH:          jump_base_o = pc_q;
      OP_JALR, OP_LOAD, OP_STORE: jump_base_o = rdata1_i;
      default:                    jump_base_o = '0;
    endcase
  end

  assign imm_o       = dec.imm;
  assign alu_op_o    = dec.alu_op;
  assign rd_o        = dec.rd;
  assign is_jump_o   = dec.is_jump;
  assign mem_read_o  = dec.mem_read;
  assign mem_write_o = dec.mem_write;
  assign csr_write_o = dec.csr_write;
  assign system_o    = dec.system;
  assign illegal_o   = dec.illegal;
endmodule

`default_nettype wire

//--- verilog/decode_top.sv
`timescale 1ns/1ps
`default_nettype none

module decode_top import rv_pkg::*; #(
  parameter int BIT_W = 32
) (
  input  wire                   clk,
  input  wire                   rst,
  input  wire  [INST_W-1:0]     inst_i,
  input  wire  [BIT_W-1:0]      pc_i,
  input  wire                   prev_valid_i,
  output logic                  ready_o,
  input  wire                   next_ready_i,
  output logic                  valid_o,
  input  wire                   wb_valid_i,
  input  wire  [REG_ADDR_W-1:0] wb_rd_i,
  input  wire  [BIT_W-1:0]      wb_data_i,
  output logic [BIT_W-1:0]      op1_o,
  output logic [BIT_W-1:0]      op2_o,
  output logic [BIT_W-1:0]      mem_addr_o,
  output logic [BIT_W-1:0]      jump_base_o,
  output logic [31:0]           imm_o,
  output alu_op_e               alu_op_o,
  output logic [REG_ADDR_W-1:0] rd_o,
  output logic                  is_jump_o,
  output logic                  mem_read_o,
  output logic                  mem_write_o,
  output logic                  csr_write_o,
  output logic                  system_o,
  output logic                  illegal_o,
  output logic [BIT_W-1:0]      pc_o,
  output logic [INST_W-1:0]     inst_o
);
  logic [BIT_W-1:0]      rdata1;
  logic [BIT_W-1:0]      rdata2;
  logic                  busy1;
  logic                  busy2;
  logic                  issue;
  logic [REG_ADDR_W-1:0] issue_rd;

  decode_if dec_bus ();

  // decodes the held instruction
  inst_decoder i_decoder (
    .inst_i (inst_o),
    .dec    (dec_bus.dec)
  );

  operand_unit #(
    .BIT_W (BIT_W)
  ) i_operands (
    .clk        (clk),
    .rst        (rst),
    .rs1_i      (dec_bus.rs1),
    .rs2_i      (dec_bus.rs2),
    .issue_i    (issue),
    .issue_rd_i (issue_rd),
    .wb_valid_i (wb_valid_i),
    .wb_rd_i    (wb_rd_i),
    .wb_data_i  (wb_data_i),
    .rdata1_o   (rdata1),
    .rdata2_o   (rdata2),
    .busy1_o    (busy1),
    .busy2_o    (busy2)
  );

  issue_stage #(
    .BIT_W (BIT_W)
  ) i_issue (
    .clk          (clk),
    .rst          (rst),
    .inst_i       (inst_i),
    .pc_i         (pc_i),
    .prev_valid_i (prev_valid_i),
    .ready_o      (ready_o),
    .next_ready_i (next_ready_i),
    .valid_o      (valid_o),
    .held_inst_o  (inst_o),
    .dec          (dec_bus.iss),
    .rdata1_i     (rdata1),
    .rdata2_i     (rdata2),
    .busy1_i      (busy1),
    .busy2_i      (busy2),
    .issue_o      (issue),
    .issue_rd_o   (issue_rd),
    .op1_o        (op1_o),
    .op2_o        (op2_o),
    .mem_addr_o   (mem_addr_o),
    .jump_base_o  (jump_base_o),
    .imm_o        (imm_o),
    .alu_op_o     (alu_op_o),
    .rd_o         (rd_o),
    .is_jump_o    (is_jump_o),
    .mem_read_o   (mem_read_o),
    .mem_write_o  (mem_write_o),
    .csr_write_o  (csr_write_o),
    .system_o     (system_o),
    .illegal_o    (illegal_o),
    .pc_o         (pc_o)
  );
endmodule

`default_nettype wire

//--- test/tb_ref.svh
`ifndef TB_REF_SVH
`define TB_REF_SVH

typedef struct packed {
  logic            uses1;
  logic            uses2;
  logic            wr;
  logic [3:0]      rd;
  logic [31:0]     imm;
  logic [3:0]      alu;
  logic [TB_W-1:0] op1;
  logic [TB_W-1:0] op2;
  logic [TB_W-1:0] mem_addr;
  logic [TB_W-1:0] jump_base;
  logic            is_jump;
  logic            mem_read;
  logic            mem_write;
  logic            csr_write;
  logic            system;
  logic            illegal;
} dec_exp_t;

// register model, kept in step with the dut
logic [TB_W-1:0] regs_m [16];
logic [15:0]     busy_m;

function automatic logic [TB_W-1:0] model_read(input logic [3:0] a, input logic wv,
                                               input logic [3:0] wr, input logic [TB_W-1:0] wd);
  if (a == 4'd0) begin
    return '0;
  end
  if (wv && wr == a) begin
    return wd;
  end
  return regs_m[a];
endfunction

function automatic logic model_busy(input logic [3:0] a, input logic wv, input logic [3:0] wr);
  return busy_m[a] && !(wv && wr == a);
endfunction

// sel codes: 0 zero/imm, 1 pc/four, 2 register
function automatic dec_exp_t ref_decode(input logic [31:0] inst, input logic [TB_W-1:0] pc,
                                        input logic [TB_W-1:0] v1, input logic [TB_W-1:0] v2);
  dec_exp_t        e;
  logic [6:0]      opc;
  logic [2:0]      f3;
  logic [1:0]      s1;
  logic [1:0]      s2;
  logic [TB_W-1:0] sx;
  opc = inst[6:0];
  f3  = inst[14:12];
  e   = '0;
  s1  = 2'd0;
  s2  = 2'd0;
  case (opc)
    OP_LUI: begin
      e.imm = {inst[31:12], 12'b0};
      e.wr  = 1'b1;
    end
    OP_AUIPC: begin
      e.imm = {inst[31:12], 12'b0};
      e.wr  = 1'b1;
      s1    = 2'd1;
    end
    OP_JAL: begin
      e.imm       = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      s1          = 2'd1;
      s2          = 2'd1;
      e.wr        = 1'b1;
      e.is_jump   = 1'b1;
      e.jump_base = pc;
    end
    OP_JALR: begin
      e.imm       = {{20{inst[31]}}, inst[31:20]};
      e.uses1     = 1'b1;
      s1          = 2'd1;
      s2          = 2'd1;
      e.wr        = 1'b1;
      e.is_jump   = 1'b1;
      e.jump_base = v1;
    end
    OP_BRANCH: begin
      e.imm       = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      e.alu       = {1'b0, f3};
      e.uses1     = 1'b1;
      e.uses2     = 1'b1;
      s1          = 2'd2;
      s2          = 2'd2;
      e.is_jump   = 1'b1;
      e.jump_base = pc;
    end
    OP_LOAD: begin
      e.imm       = {{20{inst[31]}}, inst[31:20]};
      e.alu       = {1'b0, f3};
      e.uses1     = 1'b1;
      s1          = 2'd2;
      e.wr        = 1'b1;
      e.mem_read  = 1'b1;
      e.jump_base = v1;
    end
    OP_IMM: begin
      e.imm   = {{20{inst[31]}}, inst[31:20]};
      e.alu   = {(f3 == 3'd5) && inst[30], f3};
      e.uses1 = 1'b1;
      s1      = 2'd2;
      e.wr    = 1'b1;
    end
    OP_STORE: begin
      e.imm       = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      e.alu       = {1'b0, f3};
      e.uses1     = 1'b1;
      e.uses2     = 1'b1;
      s1          = 2'd2;
      s2          = 2'd2;
      e.mem_write = 1'b1;
      e.jump_base = v1;
    end
    OP_REG: begin
      e.alu   = {(f3 == 3'd0 || f3 == 3'd5) && inst[30], f3};
      e.uses1 = 1'b1;
      e.uses2 = 1'b1;
      s1      = 2'd2;
      s2      = 2'd2;
      e.wr    = 1'b1;
    end
    OP_SYSTEM: begin
      e.imm     = {16'b0, inst[31:20], 1'b0, f3};
      e.alu     = {1'b0, f3};
      s1        = 2'd2;
      e.is_jump = 1'b1;
      e.system  = 1'b1;
      if (f3 == 3'd0) begin
        e.csr_write = (inst[31:20] == 12'h000) || (inst[31:20] == 12'h302);
      end else if (f3 != 3'd4) begin
        e.csr_write = 1'b1;
        e.wr        = 1'b1;
        e.uses1     = !f3[2];
      end
    end
    OP_FENCE_I: e.system = 1'b1;
    default: e.illegal = 1'b1;
  endcase
  e.rd       = e.wr ? inst[10:7] : 4'd0;
  sx         = TB_W'($signed(e.imm));
  e.op1      = (s1 == 2'd1) ? pc : ((s1 == 2'd2) ? v1 : '0);
  e.op2      = (s2 == 2'd1) ? TB_W'(4) : ((s2 == 2'd2) ? v2 : sx);
  e.mem_addr = (e.mem_read || e.mem_write) ? v1 + sx : '0;
  return e;
endfunction

`endif

//--- test/tb_decode_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decode_top import rv_pkg::*; ;
  localparam int TB_W       = 32;
  localparam int NUM_TESTS  = 300;
  localparam int CLK_PERIOD = 100;
  localparam int TIMEOUT    = NUM_TESTS * 20 * CLK_PERIOD + 50 * CLK_PERIOD;

  `include "tb_ref.svh"

  logic            clk;
  logic            rst;
  logic [31:0]     inst_i;
  logic [TB_W-1:0] pc_i;
  logic            prev_valid_i;
  logic            ready_o;
  logic            next_ready_i;
  logic            valid_o;
  logic            wb_valid_i;
  logic [3:0]      wb_rd_i;
  logic [TB_W-1:0] wb_data_i;
  logic [TB_W-1:0] op1_o;
  logic [TB_W-1:0] op2_o;
  logic [TB_W-1:0] mem_addr_o;
  logic [TB_W-1:0] jump_base_o;
  logic [31:0]     imm_o;
  alu_op_e         alu_op_o;
  logic [3:0]      rd_o;
  logic            is_jump_o;
  logic            mem_read_o;
  logic            mem_write_o;
  logic            csr_write_o;
  logic            system_o;
  logic            illegal_o;
  logic [TB_W-1:0] pc_o;
  logic [31:0]     inst_o;

  int              errors;
  int              seed;
  int              sent;
  int              issued;
  logic [31:0]     inst_q [$];
  logic [TB_W-1:0] pc_q [$];

  decode_top #(
    .BIT_W (TB_W)
  ) i_dut (
    .clk          (clk),
    .rst          (rst),
    .inst_i       (inst_i),
    .pc_i         (pc_i),
    .prev_valid_i (prev_valid_i),
    .ready_o      (ready_o),
    .next_ready_i (next_ready_i),
    .valid_o      (valid_o),
    .wb_valid_i   (wb_valid_i),
    .wb_rd_i      (wb_rd_i),
    .wb_data_i    (wb_data_i),
    .op1_o        (op1_o),
    .op2_o        (op2_o),
    .mem_addr_o   (mem_addr_o),
    .jump_base_o  (jump_base_o),
    .imm_o        (imm_o),
    .alu_op_o     (alu_op_o),
    .rd_o         (rd_o),
    .is_jump_o    (is_jump_o),
    .mem_read_o   (mem_read_o),
    .mem_write_o  (mem_write_o),
    .csr_write_o  (csr_write_o),
    .system_o     (system_o),
    .illegal_o    (illegal_o),
    .pc_o         (pc_o),
    .inst_o       (inst_o)
  );

  task automatic check_field(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // class 11 is an opcode outside the base set
  function automatic logic [31:0] make_inst(input int cls, input logic [31:0] r);
    logic [6:0] opc;
    case (cls)
      0:       opc = OP_LUI;
      1:       opc = OP_AUIPC;
      2:       opc = OP_JAL;
      3:       opc = OP_JALR;
      4:       opc = OP_BRANCH;
      5:       opc = OP_LOAD;
      6:       opc = OP_STORE;
      7:       opc = OP_IMM;
      8:       opc = OP_REG;
      9:       opc = OP_SYSTEM;
      10:      opc = OP_FENCE_I;
      default: opc = 7'b1111111;
    endcase
    return {r[31:7], opc};
  endfunction

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(TIMEOUT);
    $display("timeout: the run did not finish within %0d ns", TIMEOUT);
    $display("TESTBENCH FAILED");
    $finish;
  end

  always @(posedge clk) begin
    #1;
    next_ready_i <= !rst && (($random(seed) & 3) != 0);
  end

  // writeback pulses mostly aimed at busy registers
  always @(posedge clk) begin
    logic [31:0] r;
    logic [3:0]  idx;
    #1;
    r          = $random(seed);
    wb_valid_i = 1'b0;
    if (!rst && r[0] == 1'b0) begin
      idx = r[7:4];
      if (busy_m != 16'd0 && r[3:2] != 2'd0) begin
        while (!busy_m[idx]) begin
          idx = idx + 4'd1;
        end
      end
      wb_valid_i = 1'b1;
      wb_rd_i    = idx;
      wb_data_i  = $random(seed);
    end
  end

  // comparison and model update at the falling edge where all levels are stable
  always @(negedge clk) begin
    dec_exp_t        e;
    logic [TB_W-1:0] v1;
    logic [TB_W-1:0] v2;
    logic            held;
    logic            vexp;
    logic            fire;
    e    = '0;
    held = inst_q.size() > 0;
    vexp = 1'b0;
    if (!rst) begin
      if (held) begin
        v1   = model_read(inst_q[0][18:15], wb_valid_i, wb_rd_i, wb_data_i);
        v2   = model_read(inst_q[0][23:20], wb_valid_i, wb_rd_i, wb_data_i);
        e    = ref_decode(inst_q[0], pc_q[0], v1, v2);
        vexp = !((e.uses1 && model_busy(inst_q[0][18:15], wb_valid_i, wb_rd_i)) ||
                 (e.uses2 && model_busy(inst_q[0][23:20], wb_valid_i, wb_rd_i)));
      end
      fire = vexp && next_ready_i;
      check_field("valid_o", 64'(valid_o), 64'(vexp));
      check_field("ready_o", 64'(ready_o), 64'(!held || fire));
      if (held && valid_o) begin
        check_field("inst_o", 64'(inst_o), 64'(inst_q[0]));
        check_field("pc_o", 64'(pc_o), 64'(pc_q[0]));
        check_field("op1_o", 64'(op1_o), 64'(e.op1));
        check_field("op2_o", 64'(op2_o), 64'(e.op2));
        check_field("imm_o", 64'(imm_o), 64'(e.imm));
        check_field("alu_op_o", 64'(alu_op_o), 64'(e.alu));
        check_field("rd_o", 64'(rd_o), 64'(e.rd));
        check_field("mem_addr_o", 64'(mem_addr_o), 64'(e.mem_addr));
        check_field("jump_base_o", 64'(jump_base_o), 64'(e.jump_base));
        check_field("is_jump_o", 64'(is_jump_o), 64'(e.is_jump));
        check_field("mem_read_o", 64'(mem_read_o), 64'(e.mem_read));
        check_field("mem_write_o", 64'(mem_write_o), 64'(e.mem_write));
        check_field("csr_write_o", 64'(csr_write_o), 64'(e.csr_write));
        check_field("system_o", 64'(system_o), 64'(e.system));
        check_field("illegal_o", 64'(illegal_o), 64'(e.illegal));
      end
      // issues seen on the dut handshake
      if (valid_o && next_ready_i) begin
        issued++;
      end
      // clear before set so a same-edge issue keeps rd busy
      if (wb_valid_i) begin
        if (wb_rd_i != 4'd0) begin
          regs_m[wb_rd_i] = wb_data_i;
        end
        busy_m[wb_rd_i] = 1'b0;
      end
      if (fire) begin
        if (e.wr && e.rd != 4'd0) begin
          busy_m[e.rd] = 1'b1;
        end
        void'(inst_q.pop_front());
        void'(pc_q.pop_front());
      end
      if (prev_valid_i && ready_o) begin
        inst_q.push_back(inst_i);
        pc_q.push_back(pc_i);
      end
    end
  end

  initial begin
    seed         = 32'h3cb9da78;
    errors       = 0;
    sent         = 0;
    issued       = 0;
    busy_m       = '0;
    for (int i = 0; i < 16; i++) begin
      regs_m[i] = '0;
    end
    rst          = 1'b1;
    inst_i       = '0;
    pc_i         = '0;
    prev_valid_i = 1'b0;
    next_ready_i = 1'b0;
    wb_valid_i   = 1'b0;
    wb_rd_i      = '0;
    wb_data_i    = '0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    assert (!valid_o && ready_o) else begin
      errors++;
      $display("after reset the stage is not empty and ready");
    end
    @(posedge clk);
    #1;
    for (int n = 0; n < NUM_TESTS; n++) begin
      prev_valid_i = 1'b1;
      inst_i       = make_inst({$random(seed)} % 12, $random(seed));
      pc_i         = $random(seed);
      pc_i[1:0]    = 2'b00;
      @(negedge clk);
      while (!ready_o) begin
        @(negedge clk);
      end
      sent++;
      @(posedge clk);
      #1;
      if (($random(seed) & 1) != 0) begin
        prev_valid_i = 1'b0;
        @(posedge clk);
        #1;
      end
    end
    prev_valid_i = 1'b0;
    while (inst_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (5) @(posedge clk);
    assert (issued == sent) else begin
      errors++;
      $display("instructions lost or repeated: %0d sent, %0d issued", sent, issued);
    end
    $display("errors: %0d, instructions issued: %0d", errors, issued);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end
endmodule

`default_nettype wire

//--- vlog.f
+incdir+test
verilog/rv_pkg.sv
verilog/decode_if.sv
verilog/inst_decoder.sv
verilog/operand_unit.sv
verilog/issue_stage.sv
verilog/decode_top.sv
test/tb_decode_top.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f vlog.f --top-module tb_decode_top -o sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TESTBENCH PASSED$" sim.log; then
  exit 0
fi
exit 1
